/* hw/beaconDecoder.sv */
`timescale 1ns/1ns
`include "robotSensor_defines.svh"

module beaconDecoder import robotSensorPkg::*; #(
	parameter int unsigned glitchTicks = `GLITCH_TICKS
) (
	input  logic clk,
	input  logic reset,
	input  logic towerA,
	input  logic laserSync,
	input  logic laserSign,
	output logic towerTick,
	output logic towerTurn,
	output logic [`REG_WIDTH-1:0] beaconStart,
	output logic [`REG_WIDTH-1:0] beaconEnd
);

	localparam int tickWidth = (glitchTicks > 0) ? $clog2(glitchTicks + 1) : 1;

	logic [1:0] syncTower;
	logic [1:0] syncPulse;
	logic [1:0] syncSign;
	logic towerPrev;
	logic pulsePrev;
	logic turnEdge;	// one pulse per tower revolution
	logic signHigh;
	logic [`REG_WIDTH-1:0] angle;

	beaconState_t state;
	logic [tickWidth-1:0] gapTicks;
	logic [`REG_WIDTH-1:0] pendingStart;
	logic [`REG_WIDTH-1:0] pendingEnd;
	logic captureStart;
	logic captureEnd;
	logic holdExpired;

	// ==================================================================
	// input synchronizers and tower angle
	// ==================================================================

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			syncTower <= '0;
			syncPulse <= '0;
			syncSign <= '0;
			towerPrev <= 1'b0;
			pulsePrev <= 1'b0;
		end else begin
			syncTower <= {syncTower[0], towerA};
			syncPulse <= {syncPulse[0], laserSync};
			syncSign <= {syncSign[0], laserSign};
			towerPrev <= syncTower[1];
			pulsePrev <= syncPulse[1];
		end
	end

	assign towerTick = syncTower[1] & ~towerPrev;
	assign turnEdge = syncPulse[1] & ~pulsePrev;
	assign signHigh = syncSign[1];

	// sync clears the angle, so a new turn starts from zero
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			angle <= '0;
			towerTurn <= 1'b0;
		end else if (turnEdge) begin
			angle <= '0;
			towerTurn <= ~towerTurn;
		end else begin
			angle <= angle + `REG_WIDTH'(towerTick);
		end
	end

	// ==================================================================
	// reception FSM, bridges short drops of the sign
	// ==================================================================

	assign captureStart = (state == beaconIdle) & signHigh;
	assign captureEnd = (state == beaconReceiving) & ~signHigh;
	assign holdExpired = (state == beaconGap) & (gapTicks == tickWidth'(glitchTicks));

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= beaconIdle;
			gapTicks <= '0;
			beaconStart <= '0;
			beaconEnd <= '0;
		end else begin
			case (state)
				beaconIdle: begin
					if (captureStart) begin
						state <= beaconReceiving;
					end
				end
				beaconReceiving: begin
					if (captureEnd) begin
						state <= beaconGap;
						gapTicks <= '0;
					end
				end
				beaconGap: begin
					if (holdExpired) begin
						state <= beaconIdle;
						beaconStart <= pendingStart;
						beaconEnd <= pendingEnd;
					end else if (signHigh) begin
						state <= beaconReceiving;	// glitch bridged
					end else if (towerTick) begin
						gapTicks <= gapTicks + 1'b1;
					end
				end
				default: state <= beaconIdle;
			endcase
		end
	end

	// pending angles, published only once the gap is confirmed
	always_ff @(posedge clk) begin
		if (captureStart) begin
			pendingStart <= angle;
		end
		if (captureEnd) begin
			pendingEnd <= angle;	// later falls overwrite
		end
	end

endmodule

/* hw/encoderChannel.sv */
`timescale 1ns/1ns
`include "robotSensor_defines.svh"

module encoderChannel #(
	parameter bit invertDir = 1'b0	// flips the sense of dirPositive
) (
	input  logic clk,
	input  logic reset,
	input  logic encA,
	input  logic encB,
	input  logic clearCounts,
	output logic [`REG_WIDTH-1:0] countA,
	output logic [`REG_WIDTH-1:0] countB,
	output logic dirPositive
);

	logic [1:0] syncA;	// [1] is the settled level
	logic [1:0] syncB;
	logic prevA;
	logic prevB;
	logic riseA;
	logic riseB;

	// two-flop synchronizers plus the edge history
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			syncA <= '0;
			syncB <= '0;
			prevA <= 1'b0;
			prevB <= 1'b0;
		end else begin
			syncA <= {syncA[0], encA};
			syncB <= {syncB[0], encB};
			prevA <= syncA[1];
			prevB <= syncB[1];
		end
	end

	assign riseA = syncA[1] & ~prevA;
	assign riseB = syncB[1] & ~prevB;

	// an edge that lands in the clear cycle belongs to the next window
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			countA <= '0;
			countB <= '0;
		end else if (clearCounts) begin
			countA <= `REG_WIDTH'(riseA);
			countB <= `REG_WIDTH'(riseB);
		end else begin
			countA <= countA + `REG_WIDTH'(riseA);
			countB <= countB + `REG_WIDTH'(riseB);
		end
	end

	// B already high when A rises means B leads
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			dirPositive <= 1'b0;
		end else if (riseA) begin
			dirPositive <= syncB[1] ^ invertDir;
		end
	end

endmodule

/* hw/robotSensorPkg.sv */
`include "robotSensor_defines.svh"

package robotSensorPkg;

	// status register layout, top bit first
	typedef struct packed {
		logic towerTurn;	// flips on every sync pulse
		logic reserved;
		logic startIn;
		logic [`NUM_SWITCHES-1:0] limitSwitch;
		logic [1:0] odoDir;	// {right, left}
		logic gripperDir;
		logic [1:0] rakeDir;	// {right, left}
		logic [1:0] propDir;	// {right, left}
		logic boardId;
	} statusWord_t;

	// one register word, plain data or the decoded status flags
	typedef union packed {
		logic [`REG_WIDTH-1:0] raw;
		statusWord_t status;
	} regWord_t;

	// beacon reception states
	typedef enum logic [1:0] {
		beaconIdle,
		beaconReceiving,
		beaconGap	// sign low, waiting out the hold-off
	} beaconState_t;

endpackage

/* hw/robotSensorTop.sv */
`timescale 1ns/1ns
`include "robotSensor_defines.svh"

module robotSensorTop import robotSensorPkg::*; #(
	parameter int unsigned windowCycles = `SPEED_WINDOW_CYCLES,
	parameter int unsigned glitchTicks = `GLITCH_TICKS
) (
	input  logic clk,
	input  logic reset,
	input  logic [`NUM_AXES-1:0] encA,
	input  logic [`NUM_AXES-1:0] encB,
	input  logic towerA,
	input  logic laserSync,
	input  logic laserSign,
	input  logic [`NUM_SWITCHES-1:0] limitSwitch,
	input  logic startIn,
	input  logic boardId,
	input  logic [1:0] key,
	input  logic wbCyc,
	input  logic wbStb,
	input  logic wbWe,
	input  logic [`ADR_WIDTH-1:0] wbAdr,
	input  logic [`REG_WIDTH-1:0] wbDatIn,
	output regWord_t wbDatOut,
	output logic wbAck,
	output logic [1:0] irqN
);

	localparam logic [`NUM_AXES-1:0] invertMask = `DIR_INVERT_MASK;

	logic [`NUM_AXES-1:0][`REG_WIDTH-1:0] countA;
	logic [`NUM_AXES-1:0][`REG_WIDTH-1:0] countB;
	logic [`NUM_AXES-1:0][`REG_WIDTH-1:0] axisSpeed;
	logic [`NUM_AXES-1:0] axisDir;
	logic clearCounts;
	logic towerTick;
	logic towerTurn;
	logic [`REG_WIDTH-1:0] towerSpeed;
	logic [`REG_WIDTH-1:0] beaconStart;
	logic [`REG_WIDTH-1:0] beaconEnd;

	// ==================================================================
	// encoder axes
	// ==================================================================

	for (genvar g = 0; g < `NUM_AXES; g++) begin : genAxis
		encoderChannel #(.invertDir(invertMask[g])) i_encoder (
			.clk(clk),
			.reset(reset),
			.encA(encA[g]),
			.encB(encB[g]),
			.clearCounts(clearCounts),
			.countA(countA[g]),
			.countB(countB[g]),
			.dirPositive(axisDir[g])
		);
	end

	speedSampler #(.windowCycles(windowCycles)) i_speedSampler (
		.clk(clk),
		.reset(reset),
		.countA(countA),
		.countB(countB),
		.towerTick(towerTick),
		.clearCounts(clearCounts),
		.axisSpeed(axisSpeed),
		.towerSpeed(towerSpeed)
	);

	// tower angle and beacon
	beaconDecoder #(.glitchTicks(glitchTicks)) i_beaconDecoder (
		.clk(clk),
		.reset(reset),
		.towerA(towerA),
		.laserSync(laserSync),
		.laserSign(laserSign),
		.towerTick(towerTick),
		.towerTurn(towerTurn),
		.beaconStart(beaconStart),
		.beaconEnd(beaconEnd)
	);

	wbRegisterFile i_registerFile (
		.clk(clk),
		.reset(reset),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatIn(wbDatIn),
		.wbDatOut(wbDatOut),
		.wbAck(wbAck),
		.axisSpeed(axisSpeed),
		.axisDir(axisDir),
		.towerSpeed(towerSpeed),
		.beaconStart(beaconStart),
		.beaconEnd(beaconEnd),
		.towerTurn(towerTurn),
		.limitSwitch(limitSwitch),
		.startIn(startIn),
		.boardId(boardId),
		.key(key),
		.irqN(irqN)
	);

endmodule

/* hw/robotSensor_defines.svh */
`ifndef ROBOT_SENSOR_DEFINES_SVH
`define ROBOT_SENSOR_DEFINES_SVH

// word and bus sizes
`define REG_WIDTH 16
`define ADR_WIDTH 4
`define NUM_AXES 7
`define NUM_SWITCHES 5

// axis order, also the order of the speed registers
`define AXIS_PROP_LEFT 0
`define AXIS_PROP_RIGHT 1
`define AXIS_ODO_LEFT 2
`define AXIS_ODO_RIGHT 3
`define AXIS_GRIPPER 4
`define AXIS_RAKE_LEFT 5
`define AXIS_RAKE_RIGHT 6

// register map, word addresses
`define REG_STATUS 0
`define REG_SPEED_BASE 1	// one word per axis, 1 to 7
`define REG_TOWER_SPEED 8
`define REG_BEACON_START 9
`define REG_BEACON_END 10
`define REG_CONFIG 11

`define SPEED_WINDOW_CYCLES 500000	// 10 ms at 50 MHz
`define GLITCH_TICKS 20	// in tower ticks

// right propulsion and left odometry are mounted mirrored
`define DIR_INVERT_MASK 7'b0000110

`endif

/* hw/speedSampler.sv */
`timescale 1ns/1ns
`include "robotSensor_defines.svh"

module speedSampler #(
	parameter int unsigned windowCycles = `SPEED_WINDOW_CYCLES
) (
	input  logic clk,
	input  logic reset,
	input  logic [`NUM_AXES-1:0][`REG_WIDTH-1:0] countA,
	input  logic [`NUM_AXES-1:0][`REG_WIDTH-1:0] countB,
	input  logic towerTick,
	output logic clearCounts,
	output logic [`NUM_AXES-1:0][`REG_WIDTH-1:0] axisSpeed,
	output logic [`REG_WIDTH-1:0] towerSpeed
);

	localparam int winWidth = (windowCycles > 1) ? $clog2(windowCycles) : 1;

	logic [winWidth-1:0] winCount;
	logic windowEnd;
	logic [`REG_WIDTH-1:0] towerCount;
	logic [`NUM_AXES-1:0][`REG_WIDTH:0] pairSum;	// one spare bit for the carry

	// ==================================================================
	// measurement window
	// ==================================================================

	assign windowEnd = (winCount == winWidth'(windowCycles - 1));
	assign clearCounts = windowEnd;	// counters restart next cycle

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			winCount <= '0;
		end else if (windowEnd) begin
			winCount <= '0;
		end else begin
			winCount <= winCount + 1'b1;
		end
	end

	// tower ticks are counted here, the axis edges in the channels
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			towerCount <= '0;
		end else if (windowEnd) begin
			towerCount <= `REG_WIDTH'(towerTick);
		end else begin
			towerCount <= towerCount + `REG_WIDTH'(towerTick);
		end
	end

	// ==================================================================
	// speed latch
	// ==================================================================

	// both phases are counted, so half the sum is full cycles per window
	always_comb begin
		for (int i = 0; i < `NUM_AXES; i++) begin
			pairSum[i] = {1'b0, countA[i]} + {1'b0, countB[i]};
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			axisSpeed <= '0;
			towerSpeed <= '0;
		end else if (windowEnd) begin
			for (int i = 0; i < `NUM_AXES; i++) begin
				axisSpeed[i] <= pairSum[i][`REG_WIDTH:1];
			end
			towerSpeed <= towerCount;
		end
	end

endmodule

/* hw/wbRegisterFile.sv */
`timescale 1ns/1ns
`include "robotSensor_defines.svh"

module wbRegisterFile import robotSensorPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic wbCyc,
	input  logic wbStb,
	input  logic wbWe,
	input  logic [`ADR_WIDTH-1:0] wbAdr,
	input  logic [`REG_WIDTH-1:0] wbDatIn,
	output regWord_t wbDatOut,
	output logic wbAck,
	input  logic [`NUM_AXES-1:0][`REG_WIDTH-1:0] axisSpeed,
	input  logic [`NUM_AXES-1:0] axisDir,
	input  logic [`REG_WIDTH-1:0] towerSpeed,
	input  logic [`REG_WIDTH-1:0] beaconStart,
	input  logic [`REG_WIDTH-1:0] beaconEnd,
	input  logic towerTurn,
	input  logic [`NUM_SWITCHES-1:0] limitSwitch,
	input  logic startIn,
	input  logic boardId,
	input  logic [1:0] key,
	output logic [1:0] irqN
);

	localparam int syncWidth = `NUM_SWITCHES + 4;

	logic [syncWidth-1:0] syncStage;
	logic [syncWidth-1:0] syncOut;
	logic [`NUM_SWITCHES-1:0] switchSync;
	logic startSync;
	logic idSync;
	logic [1:0] keySync;
	logic [`REG_WIDTH-1:0] configReg;	// bits 1:0 enable the key interrupts
	regWord_t statusWord;
	regWord_t readData;
	logic request;
	logic speedHit;
	logic [`ADR_WIDTH-1:0] speedIdx;

	// ==================================================================
	// slow inputs and status word
	// ==================================================================

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			syncStage <= '0;
			syncOut <= '0;
		end else begin
			syncStage <= {key, boardId, startIn, limitSwitch};
			syncOut <= syncStage;
		end
	end

	assign {keySync, idSync, startSync, switchSync} = syncOut;

	always_comb begin
		statusWord.status.towerTurn = towerTurn;
		statusWord.status.reserved = 1'b0;
		statusWord.status.startIn = startSync;
		statusWord.status.limitSwitch = switchSync;
		statusWord.status.odoDir = {axisDir[`AXIS_ODO_RIGHT], axisDir[`AXIS_ODO_LEFT]};
		statusWord.status.gripperDir = axisDir[`AXIS_GRIPPER];
		statusWord.status.rakeDir = {axisDir[`AXIS_RAKE_RIGHT], axisDir[`AXIS_RAKE_LEFT]};
		statusWord.status.propDir = {axisDir[`AXIS_PROP_RIGHT], axisDir[`AXIS_PROP_LEFT]};
		statusWord.status.boardId = idSync;
	end

	// ==================================================================
	// Wishbone slave
	// ==================================================================

	assign request = wbCyc & wbStb & ~wbAck;	// no second ack while stb is dropping
	assign speedHit = (wbAdr >= `REG_SPEED_BASE) && (wbAdr < `REG_SPEED_BASE + `NUM_AXES);
	assign speedIdx = wbAdr - `ADR_WIDTH'(`REG_SPEED_BASE);

	always_comb begin
		readData.raw = '0;	// unmapped reads return zero
		case (wbAdr)
			`REG_STATUS: readData.raw = statusWord.raw;
			`REG_TOWER_SPEED: readData.raw = towerSpeed;
			`REG_BEACON_START: readData.raw = beaconStart;
			`REG_BEACON_END: readData.raw = beaconEnd;
			`REG_CONFIG: readData.raw = configReg;
			default: begin
				if (speedHit) begin
					readData.raw = axisSpeed[speedIdx];
				end
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			wbAck <= 1'b0;
			configReg <= '0;
		end else begin
			wbAck <= request;
			if (request && wbWe && (wbAdr == `ADR_WIDTH'(`REG_CONFIG))) begin
				configReg <= wbDatIn;	// only writable register
			end
		end
	end

	always_ff @(posedge clk) begin
		if (request) begin
			wbDatOut <= readData;
		end
	end

	// key passes through when enabled, otherwise held inactive high
	assign irqN = keySync | ~configReg[1:0];

endmodule

/* list.f */
+incdir+hw
hw/robotSensorPkg.sv
hw/encoderChannel.sv
hw/speedSampler.sv
hw/beaconDecoder.sv
hw/wbRegisterFile.sv
hw/robotSensorTop.sv
tb/robotSensorTb.sv

/* tb/robotSensorTb.sv */
`timescale 1ns/1ns
`include "robotSensor_defines.svh"

module robotSensorTb import robotSensorPkg::*; ();

	localparam int windowCycles = 200;
	localparam int glitchTicks = 4;
	localparam int watchdogCycles = 60 * windowCycles;	// all tests fit in about 10 windows

	logic clk;
	logic reset;
	logic [`NUM_AXES-1:0] encA;
	logic [`NUM_AXES-1:0] encB;
	logic towerA;
	logic laserSync;
	logic laserSign;
	logic [`NUM_SWITCHES-1:0] limitSwitch;
	logic startIn;
	logic boardId;
	logic [1:0] key;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [`ADR_WIDTH-1:0] wbAdr;
	logic [`REG_WIDTH-1:0] wbDatIn;
	regWord_t wbDatOut;
	logic wbAck;
	logic [1:0] irqN;

	int errors;
	int testsRun;
	int testStart;	// error count when the current test began
	int seed;
	int cycles;	// clock edges since reset release
	statusWord_t expStatus;

	robotSensorTop #(.windowCycles(windowCycles), .glitchTicks(glitchTicks)) i_dut (
		.clk(clk), .reset(reset), .encA(encA), .encB(encB),
		.towerA(towerA), .laserSync(laserSync), .laserSign(laserSign),
		.limitSwitch(limitSwitch), .startIn(startIn), .boardId(boardId), .key(key),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatIn(wbDatIn),
		.wbDatOut(wbDatOut), .wbAck(wbAck), .irqN(irqN)
	);

	always #2 clk = ~clk;

	always @(posedge clk, posedge reset) begin
		if (reset) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
		end
	end

	// ==================================================================
	// timing and bus helpers
	// ==================================================================

	task automatic stepClock(input int n);
		repeat (n) @(posedge clk);
		#1;	// inputs move just after the edge
	endtask

	// the window latches on every edge that brings cycles to a multiple of the length
	task automatic alignWindow();
		do begin
			stepClock(1);
		end while (cycles % windowCycles != 0);
	endtask

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
			errors++;
		end
	endtask

	task automatic checkWord(input string name, input regWord_t got, input regWord_t expected);
		if (got.raw !== expected.raw) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got.raw, expected.raw);
			errors++;
		end
	endtask

	task automatic checkStatus(input string name, input statusWord_t got,
			input statusWord_t expected);
		checkValue({name, ".towerTurn"}, 16'(got.towerTurn), 16'(expected.towerTurn));
		checkValue({name, ".reserved"}, 16'(got.reserved), 16'(expected.reserved));
		checkValue({name, ".startIn"}, 16'(got.startIn), 16'(expected.startIn));
		checkValue({name, ".limitSwitch"}, 16'(got.limitSwitch), 16'(expected.limitSwitch));
		checkValue({name, ".odoDir"}, 16'(got.odoDir), 16'(expected.odoDir));
		checkValue({name, ".gripperDir"}, 16'(got.gripperDir), 16'(expected.gripperDir));
		checkValue({name, ".rakeDir"}, 16'(got.rakeDir), 16'(expected.rakeDir));
		checkValue({name, ".propDir"}, 16'(got.propDir), 16'(expected.propDir));
		checkValue({name, ".boardId"}, 16'(got.boardId), 16'(expected.boardId));
	endtask

	// ack is due on the first edge after the request
	task automatic awaitAck(input string kind, input logic [`ADR_WIDTH-1:0] adr);
		int waited;
		waited = 0;
		do begin
			stepClock(1);
			waited++;
		end while (!wbAck && waited < 8);
		if (!wbAck) begin
			$display("wishbone %s at address %0d was never acknowledged", kind, adr);
			errors++;
		end else if (waited != 1) begin
			$display("wishbone %s at address %0d acknowledged after %0d cycles instead of 1",
				kind, adr, waited);
			errors++;
		end
	endtask

	// ack lasts one cycle only
	task automatic releaseBus();
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		stepClock(1);
		if (wbAck !== 1'b0) begin
			$display("wishbone ack stayed high for more than one cycle");
			errors++;
		end
	endtask

	task automatic wbFetch(input logic [`ADR_WIDTH-1:0] adr, output regWord_t data);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b0;
		wbAdr = adr;
		awaitAck("read", adr);
		data = wbDatOut;
		releaseBus();
	endtask

	task automatic wbRead(input logic [`ADR_WIDTH-1:0] adr, input logic [15:0] expected,
			input string name);
		regWord_t data;
		regWord_t want;
		want.raw = expected;
		wbFetch(adr, data);
		checkWord(name, data, want);
	endtask

	task automatic wbWrite(input logic [`ADR_WIDTH-1:0] adr, input logic [15:0] data);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = adr;
		wbDatIn = data;
		awaitAck("write", adr);
		releaseBus();
	endtask

	task automatic readStatus();
		regWord_t data;
		wbFetch(`ADR_WIDTH'(`REG_STATUS), data);
		checkStatus("status", data.status, expStatus);	// decoded through the union
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors == testStart) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - testStart);
		end
		testStart = errors;
	endtask

	// ==================================================================
	// input drivers
	// ==================================================================

	task automatic towerPulses(input int n);
		repeat (n) begin
			towerA = 1'b1;
			stepClock(2);
			towerA = 1'b0;
			stepClock(2);
		end
	endtask

	task automatic pulseSync();
		laserSync = 1'b1;
		stepClock(2);
		laserSync = 1'b0;
		stepClock(4);
		expStatus.towerTurn = ~expStatus.towerTurn;
	endtask

	task automatic setSign(input logic level);
		laserSign = level;
		stepClock(4);	// synchronizer plus one FSM step
	endtask

	// irq bit k is the key when enabled, otherwise inactive high
	function automatic logic [1:0] expectedIrq(input logic [1:0] keyIn, input logic [15:0] cfg);
		logic [1:0] result;
		for (int k = 0; k < 2; k++) begin
			result[k] = cfg[k] ? keyIn[k] : 1'b1;
		end
		return result;
	endfunction

	// ==================================================================
	// tests
	// ==================================================================

	task automatic testResetDefaults();
		for (int a = 0; a < 16; a++) begin
			wbRead(`ADR_WIDTH'(a), 16'h0000, $sformatf("reg[%0d]", a));
		end
		for (int k = 0; k < 4; k++) begin
			key = 2'(k);
			stepClock(4);
			checkValue("irqN", 16'(irqN), 16'h0003);
		end
		key = 2'b00;
		finishTest("reset defaults");
	endtask

	task automatic testConfigIrq();
		logic [15:0] cfgValues [3];
		cfgValues = '{16'h5a01, 16'hc3f2, 16'h0003};
		foreach (cfgValues[i]) begin
			wbWrite(`ADR_WIDTH'(`REG_CONFIG), cfgValues[i]);
			wbRead(`ADR_WIDTH'(`REG_CONFIG), cfgValues[i], "config");
			for (int k = 0; k < 4; k++) begin
				key = 2'(k);
				stepClock(4);
				checkValue("irqN", 16'(irqN), 16'(expectedIrq(2'(k), cfgValues[i])));
			end
		end
		key = 2'b00;
		wbWrite(`ADR_WIDTH'(`REG_CONFIG), 16'h0000);
		wbWrite(`ADR_WIDTH'(`REG_SPEED_BASE + 2), 16'hbeef);	// read only, no effect
		wbRead(`ADR_WIDTH'(`REG_SPEED_BASE + 2), 16'h0000, "axisSpeed[2]");
		finishTest("config and interrupts");
	endtask

	task automatic testAxisSpeed();
		int cycleCount [`NUM_AXES];
		logic [`NUM_AXES-1:0] leadMask;
		logic [`NUM_AXES-1:0] expDir;
		int maxSteps;
		int phase;
		logic aLevel;
		logic bLevel;
		leadMask = 7'b0110101;	// 1 means B leads A
		maxSteps = 0;
		for (int g = 0; g < `NUM_AXES; g++) begin
			cycleCount[g] = 1 + ($unsigned($random(seed)) % 15);
			if (cycleCount[g] * 4 > maxSteps) begin
				maxSteps = cycleCount[g] * 4;
			end
		end
		alignWindow();
		stepClock(10);	// keep clear of the window start
		for (int s = 0; s < maxSteps; s++) begin
			for (int g = 0; g < `NUM_AXES; g++) begin
				if (s < cycleCount[g] * 4) begin
					phase = s % 4;
					aLevel = (phase == 1) || (phase == 2);
					bLevel = (phase == 0) || (phase == 1);
					encA[g] = leadMask[g] ? aLevel : bLevel;
					encB[g] = leadMask[g] ? bLevel : aLevel;
				end
			end
			stepClock(2);
		end
		alignWindow();
		for (int g = 0; g < `NUM_AXES; g++) begin
			wbRead(`ADR_WIDTH'(`REG_SPEED_BASE + g), 16'(cycleCount[g]),
				$sformatf("axisSpeed[%0d]", g));
		end
		expDir = leadMask ^ `DIR_INVERT_MASK;
		expStatus.propDir = {expDir[`AXIS_PROP_RIGHT], expDir[`AXIS_PROP_LEFT]};
		expStatus.odoDir = {expDir[`AXIS_ODO_RIGHT], expDir[`AXIS_ODO_LEFT]};
		expStatus.gripperDir = expDir[`AXIS_GRIPPER];
		expStatus.rakeDir = {expDir[`AXIS_RAKE_RIGHT], expDir[`AXIS_RAKE_LEFT]};
		readStatus();
		finishTest("axis speed and direction");
	endtask

	task automatic testTowerSpeed();
		alignWindow();
		stepClock(10);
		towerPulses(25);
		alignWindow();
		wbRead(`ADR_WIDTH'(`REG_TOWER_SPEED), 16'd25, "towerSpeed");
		finishTest("tower speed");
	endtask

	task automatic testBeacon();
		// short gap of 2 ticks bridged into one reception from 5 to 13
		pulseSync();
		readStatus();
		towerPulses(5);
		setSign(1'b1);
		towerPulses(3);
		setSign(1'b0);
		towerPulses(2);
		setSign(1'b1);
		towerPulses(3);
		setSign(1'b0);
		towerPulses(6);
		wbRead(`ADR_WIDTH'(`REG_BEACON_START), 16'd5, "beaconStart");
		wbRead(`ADR_WIDTH'(`REG_BEACON_END), 16'd13, "beaconEnd");

		// long gap splits it into 4 to 6 and 12 to 15
		pulseSync();
		readStatus();
		towerPulses(4);
		setSign(1'b1);
		towerPulses(2);
		setSign(1'b0);
		towerPulses(6);
		setSign(1'b1);
		towerPulses(3);
		setSign(1'b0);
		wbRead(`ADR_WIDTH'(`REG_BEACON_START), 16'd4, "beaconStart");
		wbRead(`ADR_WIDTH'(`REG_BEACON_END), 16'd6, "beaconEnd");
		towerPulses(6);
		wbRead(`ADR_WIDTH'(`REG_BEACON_START), 16'd12, "beaconStart");
		wbRead(`ADR_WIDTH'(`REG_BEACON_END), 16'd15, "beaconEnd");
		finishTest("beacon");
	endtask

	task automatic testStatusFlags();
		limitSwitch = 5'b10110;
		startIn = 1'b1;
		boardId = 1'b1;
		stepClock(4);
		expStatus.limitSwitch = limitSwitch;
		expStatus.startIn = 1'b1;
		expStatus.boardId = 1'b1;
		readStatus();
		limitSwitch = 5'b01001;
		startIn = 1'b0;
		boardId = 1'b0;
		stepClock(4);
		expStatus.limitSwitch = limitSwitch;
		expStatus.startIn = 1'b0;
		expStatus.boardId = 1'b0;
		readStatus();
		finishTest("status flags");
	endtask

	// ==================================================================
	// main sequence and watchdog
	// ==================================================================

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		encA = '0;
		encB = '0;
		towerA = 1'b0;
		laserSync = 1'b0;
		laserSign = 1'b0;
		limitSwitch = '0;
		startIn = 1'b0;
		boardId = 1'b0;
		key = 2'b00;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatIn = '0;
		errors = 0;
		testsRun = 0;
		testStart = 0;
		seed = 32'hc3ff206c;
		expStatus = '0;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;

		testResetDefaults();
		testConfigIrq();
		testAxisSpeed();
		testTowerSpeed();
		testBeacon();
		testStatusFlags();

		$display("tests run %0d, errors %0d", testsRun, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
